//--- dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ====================
// Cache geometry
// ====================

// Four ways of sixteen sets, each line holding four words
`define DC_WAYS 4
`define DC_SETS 16
`define DC_WORDS 4
`define DC_DATA_W 32
`define DC_WAY_W 2

// ====================
// Address split
// ====================

// Byte address, bits 1..0 are dropped since only whole words move
`define DC_ADDR_W 32
`define DC_WSEL_LSB 2
`define DC_WSEL_W 2
`define DC_INDEX_LSB 4
`define DC_INDEX_W 4
`define DC_TAG_LSB 8
`define DC_TAG_W 24

// Victim LFSR width and its start value after reset
`define DC_LFSR_W 8
`define DC_LFSR_SEED 8'h01

`endif

//--- dcacheBusPkg.sv
`default_nettype none

`include "dcache_params.svh"

package dcacheBusPkg;

	// ====================
	// Wishbone classic
	// ====================

	// Request from a master, shared by the CPU port and the memory port
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`DC_ADDR_W-1:0] adr;
		logic [`DC_DATA_W-1:0] dat;
	} wbReq;

	// Slave response, ack is a single-cycle pulse
	typedef struct packed {
		logic ack;
		logic [`DC_DATA_W-1:0] dat;
	} wbResp;

	// ====================
	// Cache datapath
	// ====================

	// Broadcast from the controller to every way
	typedef struct packed {
		logic [`DC_INDEX_W-1:0] index;
		logic [`DC_TAG_W-1:0] tag;
		logic [`DC_WSEL_W-1:0] wordSel;
		logic [`DC_DATA_W-1:0] wdata;
		// Store hit update of one word, gated per way by its write select
		logic writeWord;
		// One word of a line fill, also gated by the write select
		logic fillWord;
		// Commit the tag and valid bit after a fill
		logic setValid;
		// Clear the valid bit of the set in all ways at once
		logic invalSet;
	} wayReq;

	// What a single way reports for the current index and tag
	typedef struct packed {
		logic valid;
		logic hit;
		logic [`DC_DATA_W-1:0] data;
	} wayResp;

	// Combined view of all ways
	typedef struct packed {
		logic hit;
		logic [`DC_WAY_W-1:0] hitWay;
		logic [`DC_WAYS-1:0] validMask;
		logic [`DC_DATA_W-1:0] readData;
	} mergeResult;

endpackage

`default_nettype wire

//--- dcacheCtrlPkg.sv
`default_nettype none

package dcacheCtrlPkg;

	// Controller FSM states
	typedef enum logic [2:0] {
		// Waiting for a CPU cycle
		IDLE,
		// Tags are compared and the merge result is taken
		LOOKUP,
		// Four memory reads bring the line into the victim way
		FILL,
		// Tag and valid bit of the victim are written
		FILL_DONE,
		// Write-through of a store to memory
		WRITE_MEM,
		// CPU ack for one cycle
		RESPOND
	} ctrlState;

	// Operation decoded from the CPU cycle
	typedef enum logic [1:0] {
		OP_LOAD,
		OP_STORE,
		// A CPU cycle with the invalidate input high, no memory access
		OP_INVAL
	} cacheOp;

endpackage

`default_nettype wire

//--- dcacheWay.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheWay (
	input wire logic clk,
	input wire logic rst,
	input wire dcacheBusPkg::wayReq req,
	input wire logic selected,
	output dcacheBusPkg::wayResp resp
);

	// One valid bit per set, cleared by reset
	logic [`DC_SETS-1:0] validBits;

	// Tag store, one entry per set
	logic [`DC_TAG_W-1:0] tags [`DC_SETS];

	// Line data, addressed by set and word within the line
	logic [`DC_DATA_W-1:0] lines [`DC_SETS * `DC_WORDS];

	// Flat word address into the data array
	logic [`DC_INDEX_W+`DC_WSEL_W-1:0] wordAddr;

	assign wordAddr = {req.index, req.wordSel};

	// ====================
	// Valid bits
	// ====================

	// Invalidate reaches every way, while setting valid only touches the victim
	always_ff @(posedge clk) begin
		if (rst) begin
			validBits <= '0;
		end else if (req.invalSet) begin
			validBits[req.index] <= 1'b0;
		end else if (req.setValid && selected) begin
			validBits[req.index] <= 1'b1;
		end
	end

	// ====================
	// Tag and data arrays
	// ====================

	// The tag is written together with the valid bit at the end of a fill
	always_ff @(posedge clk) begin
		if (req.setValid && selected) begin
			tags[req.index] <= req.tag;
		end
	end

	// A store hit and a fill word both land in the addressed word of this way
	always_ff @(posedge clk) begin
		if (selected && (req.writeWord || req.fillWord)) begin
			lines[wordAddr] <= req.wdata;
		end
	end

	// ====================
	// Lookup
	// ====================

	// Reads are combinational so the controller sees the result in the same cycle
	always_comb begin
		resp = '0;
		resp.valid = validBits[req.index];
		resp.hit = validBits[req.index] && (tags[req.index] == req.tag);
		resp.data = lines[wordAddr];
	end

endmodule

`default_nettype wire

//--- dcacheHitMerge.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheHitMerge (
	input wire dcacheBusPkg::wayResp resps [`DC_WAYS],
	output dcacheBusPkg::mergeResult result
);

	// One bit per way that matched the tag
	logic [`DC_WAYS-1:0] hitVec;

	// Valid bits of the indexed set across the ways
	logic [`DC_WAYS-1:0] validVec;

	// Gather the per-way flags into vectors
	always_comb begin
		hitVec = '0;
		validVec = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			hitVec[w] = resps[w].hit;
			validVec[w] = resps[w].valid;
		end
	end

	// ====================
	// Way encode and mux
	// ====================

	// Scanning from the top down lets the lowest hitting way win
	// Only one way should ever hit, but a stale duplicate must not mix data
	always_comb begin
		result = '0;
		result.hit = |hitVec;
		result.validMask = validVec;
		for (int w = `DC_WAYS - 1; w >= 0; w--) begin
			if (hitVec[w]) begin
				result.hitWay = w[`DC_WAY_W-1:0];
				result.readData = resps[w].data;
			end
		end
	end

endmodule

`default_nettype wire

//--- dcacheWayPicker.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheWayPicker (
	input wire logic clk,
	input wire logic rst,
	input wire dcacheCtrlPkg::ctrlState state,
	input wire dcacheCtrlPkg::cacheOp op,
	input wire dcacheBusPkg::mergeResult merge,
	output logic [`DC_WAYS-1:0] wayWrite
);

	// Victim source for full sets
	logic [`DC_LFSR_W-1:0] lfsr;
	logic lfsrFeedback;

	// Remembers that the current fill victim came from the LFSR
	logic fromLfsr;

	// Lowest invalid way of the indexed set
	logic anyEmpty;
	logic [`DC_WAY_W-1:0] emptyWay;

	// Way chosen in this cycle and its one-hot form
	logic [`DC_WAY_W-1:0] pickWay;
	logic pickFromLfsr;
	logic [`DC_WAYS-1:0] pickOneHot;

	// Taps 8, 6, 5 and 4, fed back into bit 0
	assign lfsrFeedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	always_comb begin
		anyEmpty = 1'b0;
		emptyWay = '0;
		for (int w = `DC_WAYS - 1; w >= 0; w--) begin
			if (!merge.validMask[w]) begin
				anyEmpty = 1'b1;
				emptyWay = w[`DC_WAY_W-1:0];
			end
		end
	end

	// A store follows its hit way, a fill prefers an empty way over the LFSR
	always_comb begin
		pickFromLfsr = 1'b0;
		if (op == dcacheCtrlPkg::OP_STORE) begin
			pickWay = merge.hitWay;
		end else if (anyEmpty) begin
			pickWay = emptyWay;
		end else begin
			pickWay = lfsr[`DC_WAY_W-1:0];
			pickFromLfsr = 1'b1;
		end
		pickOneHot = '0;
		pickOneHot[pickWay] = 1'b1;
	end

	// ====================
	// Registered choice
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			wayWrite <= {{(`DC_WAYS - 1){1'b0}}, 1'b1};
			lfsr <= `DC_LFSR_SEED;
			fromLfsr <= 1'b0;
		end else begin
			case (state)
			dcacheCtrlPkg::LOOKUP: begin
				// Latch on a store hit or a load miss, otherwise hold the last choice
				if ((op == dcacheCtrlPkg::OP_STORE && merge.hit) ||
					(op == dcacheCtrlPkg::OP_LOAD && !merge.hit)) begin
					wayWrite <= pickOneHot;
					fromLfsr <= pickFromLfsr && (op == dcacheCtrlPkg::OP_LOAD);
				end
			end
			dcacheCtrlPkg::FILL_DONE: begin
				// Step once per fill that consumed an LFSR victim
				if (fromLfsr) begin
					lfsr <= {lfsr[`DC_LFSR_W-2:0], lfsrFeedback};
					fromLfsr <= 1'b0;
				end
			end
			default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- dcacheController.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheController (
	input wire logic clk,
	input wire logic rst,
	input wire dcacheBusPkg::wbReq cpuReq,
	input wire logic cpuInval,
	output dcacheBusPkg::wbResp cpuResp,
	output dcacheBusPkg::wbReq memReq,
	input wire dcacheBusPkg::wbResp memResp,
	input wire dcacheBusPkg::mergeResult merge,
	output dcacheBusPkg::wayReq toWays,
	output dcacheCtrlPkg::ctrlState state,
	output dcacheCtrlPkg::cacheOp op
);

	dcacheCtrlPkg::ctrlState nextState;
	dcacheCtrlPkg::cacheOp decodedOp;

	// CPU request held for the whole operation
	logic [`DC_ADDR_W-1:0] reqAddr;
	logic [`DC_DATA_W-1:0] reqData;
	logic [`DC_TAG_W-1:0] reqTag;
	logic [`DC_INDEX_W-1:0] reqIndex;
	logic [`DC_WSEL_W-1:0] reqWord;

	// Word of the line being fetched, also the fill address offset
	logic [`DC_WSEL_W-1:0] fillCount;
	logic fillLast;

	// Store hit seen in lookup, consumed by the word write that follows
	logic storeHit;

	// Load data returned to the CPU
	logic [`DC_DATA_W-1:0] respData;

	assign reqTag = reqAddr[`DC_TAG_LSB +: `DC_TAG_W];
	assign reqIndex = reqAddr[`DC_INDEX_LSB +: `DC_INDEX_W];
	assign reqWord = reqAddr[`DC_WSEL_LSB +: `DC_WSEL_W];
	assign fillLast = (int'(fillCount) == `DC_WORDS - 1);

	// The invalidate input rides along with stb and overrides the direction
	always_comb begin
		if (cpuInval) begin
			decodedOp = dcacheCtrlPkg::OP_INVAL;
		end else if (cpuReq.we) begin
			decodedOp = dcacheCtrlPkg::OP_STORE;
		end else begin
			decodedOp = dcacheCtrlPkg::OP_LOAD;
		end
	end

	// ====================
	// FSM
	// ====================

	always_comb begin
		nextState = state;
		case (state)
		dcacheCtrlPkg::IDLE:
			if (cpuReq.cyc && cpuReq.stb) nextState = dcacheCtrlPkg::LOOKUP;
		dcacheCtrlPkg::LOOKUP:
			case (op)
			dcacheCtrlPkg::OP_LOAD:
				nextState = merge.hit ? dcacheCtrlPkg::RESPOND : dcacheCtrlPkg::FILL;
			dcacheCtrlPkg::OP_STORE: nextState = dcacheCtrlPkg::WRITE_MEM;
			default: nextState = dcacheCtrlPkg::RESPOND;
			endcase
		dcacheCtrlPkg::FILL:
			if (memResp.ack && fillLast) nextState = dcacheCtrlPkg::FILL_DONE;
		dcacheCtrlPkg::FILL_DONE: nextState = dcacheCtrlPkg::RESPOND;
		dcacheCtrlPkg::WRITE_MEM:
			if (memResp.ack) nextState = dcacheCtrlPkg::RESPOND;
		default: nextState = dcacheCtrlPkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dcacheCtrlPkg::IDLE;
			op <= dcacheCtrlPkg::OP_LOAD;
			fillCount <= '0;
			storeHit <= 1'b0;
		end else begin
			state <= nextState;
			if (state == dcacheCtrlPkg::IDLE && cpuReq.cyc && cpuReq.stb) op <= decodedOp;
			// Every fill starts at word 0 of the line
			if (state == dcacheCtrlPkg::LOOKUP) begin
				fillCount <= '0;
				storeHit <= merge.hit && (op == dcacheCtrlPkg::OP_STORE);
			end
			if (state == dcacheCtrlPkg::FILL && memResp.ack) fillCount <= fillCount + 1'b1;
			if (state == dcacheCtrlPkg::WRITE_MEM) storeHit <= 1'b0;
		end
	end

	// Request capture and the returned word
	always_ff @(posedge clk) begin
		if (state == dcacheCtrlPkg::IDLE) begin
			reqAddr <= cpuReq.adr;
			reqData <= cpuReq.dat;
		end
		if (state == dcacheCtrlPkg::LOOKUP) respData <= merge.readData;
		// The requested word is grabbed as it streams past during the fill
		if (state == dcacheCtrlPkg::FILL && memResp.ack && fillCount == reqWord)
			respData <= memResp.dat;
	end

	// ====================
	// Outputs
	// ====================

	always_comb begin
		cpuResp = '0;
		cpuResp.ack = (state == dcacheCtrlPkg::RESPOND);
		cpuResp.dat = respData;
	end

	// Memory master, one single-beat cycle per fill word or store
	always_comb begin
		memReq = '0;
		if (state == dcacheCtrlPkg::FILL) begin
			memReq.cyc = 1'b1;
			memReq.stb = 1'b1;
			memReq.adr = {reqTag, reqIndex, fillCount, {`DC_WSEL_LSB{1'b0}}};
		end else if (state == dcacheCtrlPkg::WRITE_MEM) begin
			memReq.cyc = 1'b1;
			memReq.stb = 1'b1;
			memReq.we = 1'b1;
			memReq.adr = reqAddr;
			memReq.dat = reqData;
		end
	end

	// The hit way is registered by the picker at the end of lookup,
	// so the store word write lands on the first write-through edge
	always_comb begin
		toWays = '0;
		toWays.index = reqIndex;
		toWays.tag = reqTag;
		toWays.wordSel = (state == dcacheCtrlPkg::FILL) ? fillCount : reqWord;
		toWays.wdata = (state == dcacheCtrlPkg::FILL) ? memResp.dat : reqData;
		toWays.writeWord = (state == dcacheCtrlPkg::WRITE_MEM) && storeHit;
		toWays.fillWord = (state == dcacheCtrlPkg::FILL) && memResp.ack;
		toWays.setValid = (state == dcacheCtrlPkg::FILL_DONE);
		toWays.invalSet = (state == dcacheCtrlPkg::LOOKUP) && (op == dcacheCtrlPkg::OP_INVAL);
	end

endmodule

`default_nettype wire

//--- dcacheTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheTop (
	input wire logic clk,
	input wire logic rst,
	input wire dcacheBusPkg::wbReq cpuReq,
	input wire logic cpuInval,
	output dcacheBusPkg::wbResp cpuResp,
	output dcacheBusPkg::wbReq memReq,
	input wire dcacheBusPkg::wbResp memResp
);

	// Controller broadcast and the way responses it gets back
	dcacheBusPkg::wayReq toWays;
	dcacheBusPkg::wayResp wayResps [`DC_WAYS];
	dcacheBusPkg::mergeResult merge;

	// Controller status seen by the picker
	dcacheCtrlPkg::ctrlState state;
	dcacheCtrlPkg::cacheOp op;

	// One-hot write select, one bit per way
	logic [`DC_WAYS-1:0] wayWrite;

	dcacheController u_dcacheController (
		.clk(clk),
		.rst(rst),
		.cpuReq(cpuReq),
		.cpuInval(cpuInval),
		.cpuResp(cpuResp),
		.memReq(memReq),
		.memResp(memResp),
		.merge(merge),
		.toWays(toWays),
		.state(state),
		.op(op)
	);

	// ====================
	// Ways
	// ====================

	for (genvar w = 0; w < `DC_WAYS; w++) begin : gWay
		dcacheWay u_dcacheWay (
			.clk(clk),
			.rst(rst),
			.req(toWays),
			.selected(wayWrite[w]),
			.resp(wayResps[w])
		);
	end

	dcacheHitMerge u_dcacheHitMerge (
		.resps(wayResps),
		.result(merge)
	);

	dcacheWayPicker u_dcacheWayPicker (
		.clk(clk),
		.rst(rst),
		.state(state),
		.op(op),
		.merge(merge),
		.wayWrite(wayWrite)
	);

endmodule

`default_nettype wire

//--- tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
	parameter int period = 10,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic rst
);

	// Free-running clock that starts low
	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Reset is high from time zero and drops just after the last reset edge
	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- tbDcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module tbDcache;

	localparam int clkPeriod = 10;
	localparam int numOps = 400;
	localparam int cyclesPerOp = 40;
	localparam int timeoutNs = numOps * cyclesPerOp * clkPeriod;
	localparam int baseSeed = 68;
	// More tags than ways per set, so fills have to evict
	localparam int tagCount = 6;
	localparam int memDepth = 512;

	logic clk;
	logic rst;
	dcacheBusPkg::wbReq cpuReq;
	logic cpuInval;
	dcacheBusPkg::wbResp cpuResp;
	dcacheBusPkg::wbReq memReq;
	dcacheBusPkg::wbResp memResp;

	// One generator for the CPU traffic and the memory wait states
	integer seed = baseSeed;
	int cycleNum = 0;

	// Flat word memory behind the cache
	// It is indexed by address bits 10..2
	logic [`DC_DATA_W-1:0] memWords [memDepth];
	// Every memory cycle acked during the current CPU operation
	dcacheBusPkg::wbReq busLog [$];
	int memAckCycle;

	// Tag model of the cache contents and the victim LFSR
	logic modelValid [`DC_SETS][`DC_WAYS];
	logic [`DC_TAG_W-1:0] modelTag [`DC_SETS][`DC_WAYS];
	logic [`DC_LFSR_W-1:0] modelLfsr;

	tbClockGen #(.period(clkPeriod), .resetCycles(2)) u_tbClockGen (
		.clk(clk),
		.rst(rst)
	);

	dcacheTop u_dcacheTop (
		.clk(clk),
		.rst(rst),
		.cpuReq(cpuReq),
		.cpuInval(cpuInval),
		.cpuResp(cpuResp),
		.memReq(memReq),
		.memResp(memResp)
	);

	always @(posedge clk) begin
		cycleNum <= cycleNum + 1;
	end

	// ====================
	// Checks
	// ====================

	task automatic abortRun();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input logic [`DC_DATA_W-1:0] expected,
		input logic [`DC_DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
			abortRun();
		end
	endtask

	// The data field only matters on a write
	task automatic checkWbReq(input string name, input dcacheBusPkg::wbReq expected,
		input dcacheBusPkg::wbReq actual);
		if (actual.cyc !== expected.cyc || actual.stb !== expected.stb ||
			actual.we !== expected.we || actual.adr !== expected.adr ||
			(expected.we && actual.dat !== expected.dat)) begin
			$display("mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkBusCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkCycles(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
			abortRun();
		end
	endtask

	// ====================
	// Models
	// ====================

	// Start value of a memory word that mixes every address bit
	function automatic logic [`DC_DATA_W-1:0] fillPattern(input int wordIdx);
		return (wordIdx + 1) * 32'h9E37_79B1;
	endfunction

	function automatic logic lineCached(input logic [`DC_INDEX_W-1:0] set,
		input logic [`DC_TAG_W-1:0] tag);
		logic found;
		found = 1'b0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (modelValid[set][w] && modelTag[set][w] == tag) found = 1'b1;
		end
		return found;
	endfunction

	// Lowest empty way first, else the LFSR picks and then steps once
	task automatic allocateLine(input logic [`DC_INDEX_W-1:0] set,
		input logic [`DC_TAG_W-1:0] tag);
		int victim;
		victim = -1;
		for (int w = `DC_WAYS - 1; w >= 0; w--) begin
			if (!modelValid[set][w]) victim = w;
		end
		if (victim < 0) begin
			victim = modelLfsr[1:0];
			// Taps 8, 6, 5 and 4 of a left-shifting register
			modelLfsr = {modelLfsr[6:0],
				modelLfsr[7] ^ modelLfsr[5] ^ modelLfsr[4] ^ modelLfsr[3]};
		end
		modelValid[set][victim] = 1'b1;
		modelTag[set][victim] = tag;
	endtask

	// Memory slave with 0 to 3 wait cycles and a one-cycle ack
	initial begin : memoryModel
		int waitLeft;
		logic busy;
		int wordIdx;
		memResp = '0;
		busy = 1'b0;
		waitLeft = 0;
		for (int i = 0; i < memDepth; i++) begin
			memWords[i] = fillPattern(i);
		end
		forever begin
			@(posedge clk);
			#1;
			if (memResp.ack) begin
				memResp = '0;
			end else if (memReq.cyc && memReq.stb) begin
				if (!busy) begin
					busy = 1'b1;
					waitLeft = $unsigned($random(seed)) % 4;
				end
				if (waitLeft > 0) begin
					waitLeft--;
				end else if (memReq.adr[`DC_ADDR_W-1:11] != '0) begin
					$display("memory access outside the modeled address range at 0x%h",
						memReq.adr);
					abortRun();
				end else begin
					wordIdx = memReq.adr[10:2];
					busLog.push_back(memReq);
					memAckCycle = cycleNum;
					if (memReq.we) memWords[wordIdx] = memReq.dat;
					memResp.ack = 1'b1;
					memResp.dat = memReq.we ? '0 : memWords[wordIdx];
					busy = 1'b0;
				end
			end
		end
	end

	// Ends the run if the DUT stops answering
	initial begin : watchdog
		#(timeoutNs);
		$display("Timeout: the run did not finish within %0d ns", timeoutNs);
		$display("Checks failed");
		$fatal(1);
	end

	// ====================
	// Stimulus
	// ====================

	// Ack is sampled on the falling edge, away from the rising edge updates
	task automatic waitForAck(output int cycle, output logic [`DC_DATA_W-1:0] data);
		do begin
			@(negedge clk);
		end while (cpuResp.ack !== 1'b1);
		cycle = cycleNum;
		data = cpuResp.dat;
	endtask

	initial begin : stimulus
		int opSel;
		int gap;
		int loadHits;
		int loadMisses;
		int driveCycle;
		int ackCycle;
		logic [`DC_DATA_W-1:0] ackData;
		logic [`DC_ADDR_W-1:0] addr;
		logic [`DC_DATA_W-1:0] wdata;
		logic [`DC_INDEX_W-1:0] set;
		logic [`DC_TAG_W-1:0] tag;
		logic hit;
		dcacheCtrlPkg::cacheOp kind;
		dcacheBusPkg::wbReq expReq;

		cpuReq = '0;
		cpuInval = 1'b0;
		loadHits = 0;
		loadMisses = 0;
		modelLfsr = `DC_LFSR_SEED;
		for (int s = 0; s < `DC_SETS; s++) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				modelValid[s][w] = 1'b0;
				modelTag[s][w] = '0;
			end
		end

		wait (rst == 1'b0);
		for (int n = 0; n < numOps; n++) begin
			@(posedge clk);
			#1;
			cpuReq = '0;
			cpuInval = 1'b0;
			gap = $unsigned($random(seed)) % 3;
			if (gap > 0) begin
				repeat (gap) @(posedge clk);
				#1;
			end

			// Roughly half loads, 40 percent stores and the rest invalidates
			opSel = $unsigned($random(seed)) % 100;
			if (opSel < 50) kind = dcacheCtrlPkg::OP_LOAD;
			else if (opSel < 90) kind = dcacheCtrlPkg::OP_STORE;
			else kind = dcacheCtrlPkg::OP_INVAL;
			tag = `DC_TAG_W'(($unsigned($random(seed)) % tagCount) + 1);
			set = `DC_INDEX_W'(($unsigned($random(seed)) % 4) * 5);
			addr = {tag, set, 4'($random(seed))};
			wdata = $random(seed);
			hit = lineCached(set, tag);

			busLog.delete();
			driveCycle = cycleNum;
			cpuReq.cyc = 1'b1;
			cpuReq.stb = 1'b1;
			cpuReq.adr = addr;
			cpuReq.we = (kind == dcacheCtrlPkg::OP_STORE);
			cpuReq.dat = wdata;
			cpuInval = (kind == dcacheCtrlPkg::OP_INVAL);
			waitForAck(ackCycle, ackData);

			case (kind)
			dcacheCtrlPkg::OP_LOAD: begin
				if (hit) begin
					loadHits++;
					checkBusCount("memory cycles on load hit", 0, busLog.size());
					checkCycles("load hit ack latency", 2, ackCycle - driveCycle);
				end else begin
					// The whole line is read in word order into the victim way
					loadMisses++;
					checkBusCount("memory cycles on load miss", `DC_WORDS, busLog.size());
					for (int w = 0; w < `DC_WORDS; w++) begin
						expReq = '0;
						expReq.cyc = 1'b1;
						expReq.stb = 1'b1;
						expReq.adr = {tag, set, 2'(w), 2'b00};
						checkWbReq($sformatf("memReq fill word %0d", w), expReq, busLog[w]);
					end
					allocateLine(set, tag);
				end
				checkWord("cpuResp.dat", memWords[addr[10:2]], ackData);
			end
			dcacheCtrlPkg::OP_STORE: begin
				// Write-through on hit and miss alike, with no allocation on a miss
				checkBusCount("memory cycles on store", 1, busLog.size());
				expReq = '0;
				expReq.cyc = 1'b1;
				expReq.stb = 1'b1;
				expReq.we = 1'b1;
				expReq.adr = addr;
				expReq.dat = wdata;
				checkWbReq("memReq store", expReq, busLog[0]);
				checkCycles("store ack after memory ack", 1, ackCycle - memAckCycle);
			end
			default: begin
				checkBusCount("memory cycles on invalidate", 0, busLog.size());
				checkCycles("invalidate ack latency", 2, ackCycle - driveCycle);
				for (int w = 0; w < `DC_WAYS; w++) begin
					modelValid[set][w] = 1'b0;
				end
			end
			endcase
		end

		@(posedge clk);
		#1;
		cpuReq = '0;
		cpuInval = 1'b0;
		$display("Ran %0d operations with %0d load hits and %0d load misses",
			numOps, loadHits, loadMisses);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
dcacheBusPkg.sv
dcacheCtrlPkg.sv
dcacheWay.sv
dcacheHitMerge.sv
dcacheWayPicker.sv
dcacheController.sv
dcacheTop.sv
tbClockGen.sv
tbDcache.sv
